/* ntm_dot_product_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_dot_product_top import ntm_pkg::*; (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire                  DATA_A_IN_ENABLE,
  input  wire                  DATA_B_IN_ENABLE,
  input  wire [DATA_SIZE-1:0]  MODULO_IN,
  input  wire [INDEX_SIZE-1:0] LENGTH_IN,
  input  wire [DATA_SIZE-1:0]  DATA_A_IN,
  input  wire [DATA_SIZE-1:0]  DATA_B_IN,
  output logic                 READY,
  output logic                 DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  // RAM port traffic
  ntm_ram_req_t          loader_req;
  ntm_ram_req_t          product_req;
  ntm_ram_req_t          ram_req;
  ntm_grant_e            grant;
  ntm_pair_t             rdata;

  // Stored pairs so far
  logic [INDEX_SIZE-1:0] pair_count;

  ////////////////////
  // Write side
  ////////////////////

  ntm_vector_loader ntm_vector_loader_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .ram_req          (loader_req),
    .pair_count       (pair_count)
  );

  // Shared port, loader first
  ntm_ram_arbiter ntm_ram_arbiter_i (
    .loader_req  (loader_req),
    .product_req (product_req),
    .ram_req     (ram_req),
    .grant       (grant)
  );

  ntm_vector_ram ntm_vector_ram_i (
    .CLK   (CLK),
    .req   (ram_req),
    .rdata (rdata)
  );

  ////////////////////
  // Read side
  ////////////////////

  ntm_scalar_product ntm_scalar_product_i (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .MODULO_IN       (MODULO_IN),
    .LENGTH_IN       (LENGTH_IN),
    .pair_count      (pair_count),
    .grant           (grant),
    .rdata           (rdata),
    .ram_req         (product_req),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT)
  );

endmodule

`default_nettype wire

/* ntm_modular_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_modular_multiplier import ntm_pkg::*; (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  start,
  input  wire [DATA_SIZE-1:0]  modulo,
  input  wire [DATA_SIZE-1:0]  data_a,
  input  wire [DATA_SIZE-1:0]  data_b,
  output logic                 ready,
  output logic [DATA_SIZE-1:0] data_out
);

  // Latched operands
  logic [DATA_SIZE-1:0]  a_q;
  logic [DATA_SIZE-1:0]  b_q;
  logic [DATA_SIZE-1:0]  mod_q;
  logic [DATA_SIZE-1:0]  acc_q;

  // Step control
  logic                  busy;
  logic [INDEX_SIZE-1:0] step_cnt;

  // One extra bit so doubling and adding never wrap
  logic [DATA_SIZE:0]    doubled;
  logic [DATA_SIZE:0]    summed;
  logic [DATA_SIZE-1:0]  acc_next;

  ////////////////////
  // Step datapath
  ////////////////////

  // Horner step over b, MSB first
  always_comb begin
    doubled = {acc_q, 1'b0};
    if (doubled >= {1'b0, mod_q}) begin
      doubled = doubled - {1'b0, mod_q};
    end
    summed = doubled + {1'b0, a_q};
    if (summed >= {1'b0, mod_q}) begin
      summed = summed - {1'b0, mod_q};
    end
    // Add a only for a set bit
    acc_next = b_q[DATA_SIZE-1] ? summed[DATA_SIZE-1:0] : doubled[DATA_SIZE-1:0];
  end

  ////////////////////
  // Control
  ////////////////////

  // DATA_SIZE steps, ready one cycle after the last
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        step_cnt <= INDEX_SIZE'(DATA_SIZE);
      end else if (busy) begin
        step_cnt <= step_cnt - 1'b1;
        // Final bit consumed here
        if (step_cnt == INDEX_SIZE'(1)) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  // Operand capture and shifting
  always_ff @(posedge CLK) begin
    if (start) begin
      a_q   <= data_a;
      b_q   <= data_b;
      mod_q <= modulo;
      acc_q <= '0;
    end else if (busy) begin
      acc_q <= acc_next;
      b_q   <= b_q << 1;
    end
  end

  // Product holds until the next start
  assign data_out = acc_q;

endmodule

`default_nettype wire

/* ntm_pkg.sv */
`default_nettype none

package ntm_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Operand, modulus and result width
  localparam int DATA_SIZE = 16;

  // Index and length width, one bit above the address so 16 fits
  localparam int INDEX_SIZE = 5;

  // Vector RAM geometry
  localparam int VECTOR_DEPTH = 16;
  localparam int ADDR_SIZE    = 4;

  ////////////////////
  // Structs
  ////////////////////

  // One stored element pair
  typedef struct packed {
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
  } ntm_pair_t;

  // One RAM access, write when we is set
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [ADDR_SIZE-1:0] addr;
    ntm_pair_t            pair;
  } ntm_ram_req_t;

  ////////////////////
  // Enums
  ////////////////////

  // Current owner of the RAM port
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_LOADER,
    GRANT_PRODUCT
  } ntm_grant_e;

  // Scalar product engine states
  typedef enum logic [2:0] {
    STARTER_STATE,
    READ_STATE,
    MULTIPLIER_STATE,
    ADDER_STATE,
    ENDER_STATE
  } ntm_product_state_e;

endpackage

`default_nettype wire

/* ntm_ram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_ram_arbiter import ntm_pkg::*; (
  input  wire ntm_ram_req_t loader_req,
  input  wire ntm_ram_req_t product_req,
  output ntm_ram_req_t      ram_req,
  output ntm_grant_e        grant
);

  ////////////////////
  // Fixed priority
  ////////////////////

  // Loader always wins, strobes upstream cannot wait
  // Engine keeps its request up and retries on a lost cycle
  always_comb begin
    if (loader_req.req) begin
      ram_req = loader_req;
      grant   = GRANT_LOADER;
    end else if (product_req.req) begin
      ram_req = product_req;
      grant   = GRANT_PRODUCT;
    end else begin
      // Idle port, nothing forwarded
      ram_req = '0;
      grant   = GRANT_NONE;
    end
  end

endmodule

`default_nettype wire

/* ntm_scalar_product.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_product import ntm_pkg::*; (
  input  wire                   CLK,
  input  wire                   RST,
  input  wire                   START,
  input  wire [DATA_SIZE-1:0]   MODULO_IN,
  input  wire [INDEX_SIZE-1:0]  LENGTH_IN,
  input  wire [INDEX_SIZE-1:0]  pair_count,
  input  wire ntm_grant_e       grant,
  input  wire ntm_pair_t        rdata,
  output ntm_ram_req_t          ram_req,
  output logic                  READY,
  output logic                  DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0]  DATA_OUT
);

  // FSM and loop state
  ntm_product_state_e    state_q;
  logic [INDEX_SIZE-1:0] index_q;
  logic [INDEX_SIZE-1:0] next_index;
  logic [INDEX_SIZE-1:0] length_q;
  logic [DATA_SIZE-1:0]  modulo_q;

  // Read granted last cycle, so rdata is valid now
  logic                  read_done;

  // Multiplier hookup
  logic                  mul_ready;
  logic [DATA_SIZE-1:0]  mul_data;

  // Modular add of accumulator and product
  logic [DATA_SIZE:0]    sum;
  logic [DATA_SIZE-1:0]  sum_red;

  assign next_index = index_q + 1'b1;

  always_comb begin
    sum     = {1'b0, DATA_OUT} + {1'b0, mul_data};
    sum_red = (sum >= {1'b0, modulo_q}) ? DATA_SIZE'(sum - {1'b0, modulo_q})
                                        : sum[DATA_SIZE-1:0];
  end

  ////////////////////
  // RAM read request
  ////////////////////

  // Only ask for elements the loader has already stored
  assign ram_req.req  = (state_q == READ_STATE) && (index_q < pair_count);
  assign ram_req.we   = 1'b0;
  assign ram_req.addr = index_q[ADDR_SIZE-1:0];
  assign ram_req.pair = '0;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q         <= STARTER_STATE;
      index_q         <= '0;
      length_q        <= '0;
      modulo_q        <= '0;
      read_done       <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Pulses by default
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      read_done       <= 1'b0;
      case (state_q)
        STARTER_STATE: begin
          // START only counts while idle
          if (START) begin
            modulo_q <= MODULO_IN;
            length_q <= LENGTH_IN;
            index_q  <= '0;
            DATA_OUT <= '0;
            state_q  <= (LENGTH_IN == '0) ? ENDER_STATE : READ_STATE;
          end
        end
        READ_STATE: begin
          // Loader may steal the port, request stays up
          if (ram_req.req && grant == GRANT_PRODUCT) begin
            read_done <= 1'b1;
            state_q   <= MULTIPLIER_STATE;
          end
        end
        MULTIPLIER_STATE: begin
          if (mul_ready) begin
            state_q <= ADDER_STATE;
          end
        end
        ADDER_STATE: begin
          // New partial sum and its strobe together
          DATA_OUT        <= sum_red;
          DATA_OUT_ENABLE <= 1'b1;
          index_q         <= next_index;
          state_q         <= (next_index == length_q) ? ENDER_STATE : READ_STATE;
        end
        ENDER_STATE: begin
          READY   <= 1'b1;
          state_q <= STARTER_STATE;
        end
        default: begin
          state_q <= STARTER_STATE;
        end
      endcase
    end
  end

  // Pair from RAM fed straight in
  ntm_modular_multiplier ntm_modular_multiplier_i (
    .CLK      (CLK),
    .RST      (RST),
    .start    (read_done),
    .modulo   (modulo_q),
    .data_a   (rdata.a),
    .data_b   (rdata.b),
    .ready    (mul_ready),
    .data_out (mul_data)
  );

endmodule

`default_nettype wire

/* ntm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_tb import ntm_pkg::*; ();

  // DUT inputs
  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic                  DATA_A_IN_ENABLE;
  logic                  DATA_B_IN_ENABLE;
  logic [DATA_SIZE-1:0]  MODULO_IN;
  logic [INDEX_SIZE-1:0] LENGTH_IN;
  logic [DATA_SIZE-1:0]  DATA_A_IN;
  logic [DATA_SIZE-1:0]  DATA_B_IN;

  // DUT outputs
  logic                  READY;
  logic                  DATA_OUT_ENABLE;
  logic [DATA_SIZE-1:0]  DATA_OUT;

  // Reference running sums of the current vector
  longint unsigned       exp_sums [0:VECTOR_DEPTH];
  longint unsigned       exp_final;
  int                    exp_len;
  logic                  all_sent;

  // Pulses seen since the last START
  int                    pulse_cnt;
  int                    ready_cnt;

  ntm_tb_clock i_clock (
    .CLK (CLK)
  );

  ntm_dot_product_top i_dut (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .MODULO_IN        (MODULO_IN),
    .LENGTH_IN        (LENGTH_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .READY            (READY),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .DATA_OUT         (DATA_OUT)
  );

  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      pulse_cnt <= 0;
      ready_cnt <= 0;
    end else if (START) begin
      pulse_cnt <= 0;
      ready_cnt <= 0;
    end else begin
      if (DATA_OUT_ENABLE) begin
        pulse_cnt <= pulse_cnt + 1;
      end
      if (READY) begin
        ready_cnt <= ready_cnt + 1;
      end
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input longint unsigned got,
                            input longint unsigned expected);
    $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
    fail_run("Value mismatch");
  endtask

  ////////////////////
  // Checks
  ////////////////////

  // Quiet outputs in reset and in the first cycle after it
  reset_quiet: assert property (@(posedge CLK)
    RST |=> (!READY && !DATA_OUT_ENABLE && DATA_OUT == '0 && !i_dut.ram_req.req))
    else fail_run("Outputs or RAM request active during or right after reset");

  // Each strobe carries the next partial sum
  partial_sum: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> DATA_OUT == exp_sums[pulse_cnt])
    else fail_value("DATA_OUT", $sampled(DATA_OUT), exp_sums[$sampled(pulse_cnt)]);

  extra_pulse: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> pulse_cnt < exp_len)
    else fail_run("DATA_OUT_ENABLE pulsed more often than LENGTH_IN");

  // READY right after the last partial sum
  ready_follows: assert property (@(posedge CLK) disable iff (RST)
    (DATA_OUT_ENABLE && pulse_cnt + 1 == exp_len) |=> READY)
    else fail_run("READY did not follow the last DATA_OUT_ENABLE");

  ready_count: assert property (@(posedge CLK) disable iff (RST)
    READY |-> pulse_cnt == exp_len)
    else fail_value("DATA_OUT_ENABLE count", $sampled(pulse_cnt), exp_len);

  ready_sum: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT == exp_final)
    else fail_value("DATA_OUT", $sampled(DATA_OUT), exp_final);

  ready_early: assert property (@(posedge CLK) disable iff (RST)
    READY |-> all_sent)
    else fail_run("READY came before the last pair was strobed");

  ready_once: assert property (@(posedge CLK) disable iff (RST)
    READY |-> ready_cnt == 0)
    else fail_run("READY pulsed more than once for one START");

  ////////////////////
  // Stimulus
  ////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  // Order 0 is together, 1 is A first and 2 is B first
  task automatic send_element(input longint unsigned a, input longint unsigned b,
                              input int order, input int gap);
    DATA_A_IN = DATA_SIZE'(a);
    DATA_B_IN = DATA_SIZE'(b);
    if (order == 0) begin
      DATA_A_IN_ENABLE = 1'b1;
      DATA_B_IN_ENABLE = 1'b1;
      step();
    end else begin
      DATA_A_IN_ENABLE = (order == 1);
      DATA_B_IN_ENABLE = (order == 2);
      step();
      DATA_A_IN_ENABLE = 1'b0;
      DATA_B_IN_ENABLE = 1'b0;
      repeat (gap) step();
      DATA_A_IN_ENABLE = (order == 2);
      DATA_B_IN_ENABLE = (order == 1);
      step();
    end
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
  endtask

  task automatic wait_ready(input int limit);
    int cycles;
    cycles = 0;
    step();
    while (!READY) begin
      if (cycles == limit) begin
        fail_run("Timeout waiting for READY");
      end
      step();
      cycles++;
    end
  endtask

  task automatic run_test(input int len, input bit mixed, input int start_delay,
                          input int elem_gap);
    longint unsigned modulus;
    longint unsigned acc;
    longint unsigned a_vec [VECTOR_DEPTH];
    longint unsigned b_vec [VECTOR_DEPTH];
    int              order [VECTOR_DEPTH];
    int              gap   [VECTOR_DEPTH];
    // Modulus in 2 .. 2^15-1 and operands already reduced
    modulus = 2 + $urandom % 32766;
    acc     = 0;
    for (int i = 0; i < len; i++) begin
      a_vec[i]    = $urandom % modulus;
      b_vec[i]    = $urandom % modulus;
      order[i]    = mixed ? $urandom % 3 : 0;
      gap[i]      = mixed ? $urandom % 4 : 0;
      acc         = (acc + (a_vec[i] * b_vec[i]) % modulus) % modulus;
      exp_sums[i] = acc;
    end
    exp_len   = len;
    exp_final = acc;
    all_sent  = 1'b0;
    START     = 1'b1;
    MODULO_IN = DATA_SIZE'(modulus);
    LENGTH_IN = INDEX_SIZE'(len);
    step();
    START = 1'b0;
    fork
      begin
        repeat (start_delay) step();
        for (int i = 0; i < len; i++) begin
          if (i > 0) begin
            repeat (elem_gap) step();
          end
          send_element(a_vec[i], b_vec[i], order[i], gap[i]);
        end
        all_sent = 1'b1;
      end
      wait_ready(2000);
    join
    // Quiet tail so a late second READY shows up
    repeat (4) step();
  endtask

  initial begin
    void'($urandom(3));
    RST              = 1'b1;
    START            = 1'b0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    MODULO_IN        = '0;
    LENGTH_IN        = '0;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;
    exp_len          = 0;
    exp_final        = 0;
    all_sent         = 1'b1;
    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b0;
    repeat (2) step();
    // Paired strobes on back-to-back cycles
    repeat (3) run_test(1 + $urandom % VECTOR_DEPTH, 1'b0, 0, 0);
    // Full burst where engine reads lose to loader writes
    run_test(VECTOR_DEPTH, 1'b0, 0, 0);
    // Split strobes with either side first and random gaps
    repeat (4) run_test(1 + $urandom % VECTOR_DEPTH, 1'b1, 0, 1);
    // Data long after START so the engine has to wait
    run_test(6, 1'b1, 40, 12);
    run_test(0, 1'b0, 0, 0);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* ntm_tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_tb_clock (
  output logic CLK
);

  // 8 ns period, starts low so time zero has no rising edge
  initial begin
    CLK = 1'b0;
    forever begin
      #4 CLK = ~CLK;
    end
  end

endmodule

`default_nettype wire

/* ntm_vector_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_loader import ntm_pkg::*; (
  input  wire                   CLK,
  input  wire                   RST,
  input  wire                   START,
  input  wire                   DATA_A_IN_ENABLE,
  input  wire                   DATA_B_IN_ENABLE,
  input  wire [DATA_SIZE-1:0]   DATA_A_IN,
  input  wire [DATA_SIZE-1:0]   DATA_B_IN,
  output ntm_ram_req_t          ram_req,
  output logic [INDEX_SIZE-1:0] pair_count
);

  // Half-full holding registers
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic                 have_a;
  logic                 have_b;

  // Completed pair waiting for its write cycle
  ntm_pair_t            wr_pair;
  logic                 wr_valid;

  // Pair closes when both sides are held or arriving
  logic                 complete;

  assign complete = (have_a | DATA_A_IN_ENABLE) & (have_b | DATA_B_IN_ENABLE);

  ////////////////////
  // Pairing
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      have_a     <= 1'b0;
      have_b     <= 1'b0;
      wr_valid   <= 1'b0;
      pair_count <= '0;
    end else if (START) begin
      // New vector, forget everything held
      have_a     <= 1'b0;
      have_b     <= 1'b0;
      wr_valid   <= 1'b0;
      pair_count <= '0;
    end else begin
      wr_valid <= complete;
      // Count advances with each write issued
      if (wr_valid) begin
        pair_count <= pair_count + 1'b1;
      end
      // Held value goes first, a second strobe on the same side stays behind
      have_a <= complete ? (have_a & DATA_A_IN_ENABLE) : (have_a | DATA_A_IN_ENABLE);
      have_b <= complete ? (have_b & DATA_B_IN_ENABLE) : (have_b | DATA_B_IN_ENABLE);
    end
  end

  // Payload path
  always_ff @(posedge CLK) begin
    if (complete) begin
      wr_pair.a <= have_a ? a_q : DATA_A_IN;
      wr_pair.b <= have_b ? b_q : DATA_B_IN;
    end
    if (DATA_A_IN_ENABLE) begin
      a_q <= DATA_A_IN;
    end
    if (DATA_B_IN_ENABLE) begin
      b_q <= DATA_B_IN;
    end
  end

  // Write goes out in the cycle after the completing strobe
  assign ram_req.req  = wr_valid;
  assign ram_req.we   = 1'b1;
  assign ram_req.addr = pair_count[ADDR_SIZE-1:0];
  assign ram_req.pair = wr_pair;

endmodule

`default_nettype wire

/* ntm_vector_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_ram import ntm_pkg::*; (
  input  wire          CLK,
  input  wire ntm_ram_req_t req,
  output ntm_pair_t    rdata
);

  // Pair storage, one entry per element index
  ntm_pair_t mem [VECTOR_DEPTH];

  ////////////////////
  // Single port
  ////////////////////

  // Write has the port when we is set
  // Read data lands one cycle after the request
  always_ff @(posedge CLK) begin
    if (req.req) begin
      if (req.we) begin
        mem[req.addr] <= req.pair;
      end else begin
        rdata <= mem[req.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
ntm_pkg.sv
ntm_vector_ram.sv
ntm_ram_arbiter.sv
ntm_vector_loader.sv
ntm_modular_multiplier.sv
ntm_scalar_product.sv
ntm_dot_product_top.sv
ntm_tb_clock.sv
ntm_tb.sv
